// File: list.f
+incdir+.
rng_pkg.sv
rng_bit_extract.sv
rng_health_monitor.sv
rng_debias.sv
rng_bit_collector.sv
adc_rng_top.sv
tb_adc_rng.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the entropy path testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --top-module tb_adc_rng -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_adc_rng)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
else
    exit 1
fi

// File: tb_adc_rng.sv
`timescale 1ns/1ps
`include "rng_settings.svh"

module tb_adc_rng;

    import rng_pkg::*;

    localparam int MAX_ROWS = 8;

    // bit i of lsbs is the lsb of sample i
    // a negative mid_read means no mid-stream read
    typedef struct packed {
        int          n_samples;
        logic [63:0] lsbs;
        int          mid_read;
        rng_vector_t exp_vector;
        rng_vector_t exp_mid;
        logic        exp_full;
        logic        exp_alarm;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    adc_sample_t sample;
    logic        sample_valid;
    logic        read;
    rng_vector_t vector;
    logic        full;
    logic        alarm;

    row_t  rows [MAX_ROWS];
    string row_names [MAX_ROWS];
    int    num_rows = 0;
    int    error_count = 0;
    int    check_count = 0;
    int    failed_rows = 0;
    logic  table_ready = 1'b0;

    always #5 clk = ~clk;

    adc_rng_top adc_rng_top_i (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .read         (read),
        .vector       (vector),
        .full         (full),
        .alarm        (alarm)
    );

    task automatic add_row(input string name, input int n, input logic [63:0] lsbs,
                           input int mid, input rng_vector_t exp_vec,
                           input rng_vector_t exp_mid, input logic exp_full,
                           input logic exp_alarm);
        row_names[num_rows]           = name;
        rows[num_rows].n_samples      = n;
        rows[num_rows].lsbs           = lsbs;
        rows[num_rows].mid_read       = mid;
        rows[num_rows].exp_vector     = exp_vec;
        rows[num_rows].exp_mid        = exp_mid;
        rows[num_rows].exp_full       = exp_full;
        rows[num_rows].exp_alarm      = exp_alarm;
        num_rows++;
    endtask

    // pairs are written msb first so the pair a then b reads as ba
    task automatic build_table();
        add_row("fill_ten", 20, 64'b10_01_10_01_10_10_01_01_10_01, -1,
                10'b0101001101, 10'b0, 1'b1, 1'b0);
        add_row("equal_pairs", 18, 64'b01_10_00_10_01_11_01_00_10, -1,
                10'b0000100110, 10'b0, 1'b0, 1'b0);
        add_row("partial_read", 8, 64'b01_01_01_10, -1,
                10'b0000001110, 10'b0, 1'b0, 1'b0);
        // sixteen ones then eight 1,0 pairs
        add_row("stuck_source", 32, 64'h5555_FFFF, -1,
                10'b0, 10'b0, 1'b0, 1'b1);
        // read lands on the clean bit of sample 7
        add_row("read_collision", 12, 64'b01_01_10_01_10_01, 7,
                10'b0000000110, 10'b0000000101, 1'b0, 1'b0);
        add_row("drop_after_full", 24, 64'b01_01_01_10_01_10_01_01_10_10_01_10, -1,
                10'b1010110010, 10'b0, 1'b1, 1'b0);
    endtask

    // reference model of the whole path stepping one raw bit at a time
    task automatic run_model(input row_t r, output rng_vector_t vec,
                             output rng_vector_t mid_vec, output logic full_o,
                             output logic alarm_o);
        int          run;
        int          fill;
        logic        last;
        logic        have_first;
        logic        first;
        logic        bit_i;
        logic        got;
        logic        out_bit;
        rng_vector_t bits;
        run        = 0;
        fill       = 0;
        last       = 1'b0;
        have_first = 1'b0;
        first      = 1'b0;
        out_bit    = 1'b0;
        bits       = '0;
        mid_vec    = '0;
        alarm_o    = 1'b0;
        for (int i = 0; i < r.n_samples; i++) begin
            bit_i = r.lsbs[i];
            got   = 1'b0;
            if (run != 0 && bit_i == last) begin
                run++;
            end else begin
                run = 1;
            end
            last = bit_i;
            if (run >= `RCT_CUTOFF) begin
                alarm_o = 1'b1;
            end
            if (!alarm_o) begin
                if (!have_first) begin
                    first      = bit_i;
                    have_first = 1'b1;
                end else begin
                    have_first = 1'b0;
                    // 0,1 gives 0 and 1,0 gives 1
                    if (first == 1'b0 && bit_i == 1'b1) begin
                        got     = 1'b1;
                        out_bit = 1'b0;
                    end else if (first == 1'b1 && bit_i == 1'b0) begin
                        got     = 1'b1;
                        out_bit = 1'b1;
                    end
                end
            end
            // the read sees the old vector and a bit arriving with it starts the next one
            if (i == r.mid_read) begin
                mid_vec = bits;
                bits    = '0;
                fill    = 0;
            end
            if (got && fill < `RNG_VECTOR_DEPTH) begin
                bits[fill] = out_bit;
                fill++;
            end
        end
        vec    = bits;
        full_o = (fill == `RNG_VECTOR_DEPTH);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[ERROR] %t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst          <= 1'b1;
        sample_valid <= 1'b0;
        read         <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic apply_row(input int idx);
        row_t        r;
        rng_vector_t m_vec;
        rng_vector_t m_mid;
        logic        m_full;
        logic        m_alarm;
        logic [31:0] rand_bits;
        int          errs_before;
        r           = rows[idx];
        errs_before = error_count;
        run_model(r, m_vec, m_mid, m_full, m_alarm);
        check_count++;
        assert (m_vec == r.exp_vector && m_mid == r.exp_mid &&
                m_full == r.exp_full && m_alarm == r.exp_alarm) else begin
            $display("table row %s does not agree with the reference model", row_names[idx]);
            error_count++;
        end

        // alarm is sticky so every row starts from reset
        apply_reset();

        // one sample per cycle and then room for the pipeline to drain
        for (int j = 0; j < r.n_samples + 4; j++) begin
            @(posedge clk);
            rand_bits = $urandom();
            if (j < r.n_samples) begin
                sample       <= {rand_bits[`ADC_WIDTH-1:1], r.lsbs[j]};
                sample_valid <= 1'b1;
            end else begin
                sample_valid <= 1'b0;
            end
            read <= (r.mid_read >= 0 && j == r.mid_read + 3);
            if (r.mid_read >= 0 && j == r.mid_read + 3) begin
                @(negedge clk);
                check_value({row_names[idx], " mid-stream vector"}, 32'(vector), 32'(m_mid));
            end
        end
        @(posedge clk);
        sample_valid <= 1'b0;
        read         <= 1'b0;

        // settle before looking at the levels
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value({row_names[idx], " full"}, 32'(full), 32'(m_full));
        check_value({row_names[idx], " alarm"}, 32'(alarm), 32'(m_alarm));
        // without a read the vector stays zero
        check_value({row_names[idx], " idle vector"}, 32'(vector), 32'(0));

        @(posedge clk);
        read <= 1'b1;
        @(negedge clk);
        check_value({row_names[idx], " vector"}, 32'(vector), 32'(m_vec));
        @(posedge clk);
        read <= 1'b0;
        @(negedge clk);
        check_value({row_names[idx], " full after read"}, 32'(full), 32'(0));

        if (error_count == errs_before) begin
            $display("row %0d %s: pass", idx, row_names[idx]);
        end else begin
            $display("row %0d %s: fail, %0d errors", idx, row_names[idx],
                     error_count - errs_before);
            failed_rows++;
        end
    endtask

    initial begin
        rst          <= 1'b1;
        sample       <= '0;
        sample_valid <= 1'b0;
        read         <= 1'b0;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(9));
        build_table();
        table_ready = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
        end
        $display("rows: %0d, failed rows: %0d, checks: %0d, errors: %0d",
                 num_rows, failed_rows, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // budget of 20 cycles per sample plus the reset of each row
    initial begin
        int total_samples;
        int limit_cycles;
        wait (table_ready);
        total_samples = 0;
        for (int i = 0; i < num_rows; i++) begin
            total_samples += rows[i].n_samples;
        end
        limit_cycles = total_samples * 20 + num_rows * 10;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the test rows did not finish within %0d clock cycles",
                 limit_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule : tb_adc_rng

// File: adc_rng_top.sv
`timescale 1ns/1ps

module adc_rng_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rng_pkg::adc_sample_t sample,
    input  logic                 sample_valid,
    input  logic                 read,
    output rng_pkg::rng_vector_t vector,
    output logic                 full,
    output logic                 alarm
);

    import rng_pkg::*;

    // pipeline links, one bit and strobe per stage
    rng_bit_t raw_bit;
    rng_bit_t checked_bit;
    rng_bit_t clean_bit;

    // sample lsb
    rng_bit_extract rng_bit_extract_i (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .raw_bit      (raw_bit)
    );

    // stuck source detection on raw bits
    rng_health_monitor rng_health_monitor_i (
        .clk         (clk),
        .rst         (rst),
        .raw_bit     (raw_bit),
        .checked_bit (checked_bit),
        .alarm       (alarm)
    );

    // bias removal
    rng_debias rng_debias_i (
        .clk         (clk),
        .rst         (rst),
        .checked_bit (checked_bit),
        .clean_bit   (clean_bit)
    );

    // output vector for the consumer
    rng_bit_collector rng_bit_collector_i (
        .clk       (clk),
        .rst       (rst),
        .clean_bit (clean_bit),
        .read      (read),
        .vector    (vector),
        .full      (full)
    );

endmodule : adc_rng_top

// File: rng_bit_collector.sv
`timescale 1ns/1ps
`include "rng_settings.svh"

module rng_bit_collector (
    input  logic                 clk,
    input  logic                 rst,
    input  rng_pkg::rng_bit_t    clean_bit,
    input  logic                 read,
    output rng_pkg::rng_vector_t vector,
    output logic                 full
);

    import rng_pkg::*;

    localparam int unsigned HEAD_W = `RNG_HEAD_WIDTH;

    typedef logic [HEAD_W-1:0] head_t;

    localparam head_t HEAD_FULL = head_t'(`RNG_VECTOR_DEPTH);

    // head is the fill count and the next write position
    head_t         head_cur;
    head_t         head_next;
    rng_vector_t   vec_cur;
    rng_vector_t   vec_next;
    rng_vector_t   fill_mask;
    logic          empty;
    collector_op_t op;

    assign op    = collector_op_t'({clean_bit.valid, read});
    assign full  = head_cur == HEAD_FULL;
    assign empty = head_cur == '0;

    // positions below the head hold bits of the current vector
    // stale bits above it never reach the output
    always_comb begin
        for (int i = 0; i < `RNG_VECTOR_DEPTH; i++) begin
            fill_mask[i] = head_t'(i) < head_cur;
        end
    end

    always_comb begin
        head_next = head_cur;
        vec_next  = vec_cur;
        vector    = '0;

        unique case (op)
            op_idle: begin
                head_next = head_cur;
            end
            op_wr: begin
                // drop the bit once the vector is complete
                if (!full) begin
                    vec_next[head_cur] = clean_bit.data;
                    head_next          = head_cur + 1'b1;
                end
            end
            op_rd: begin
                if (!empty) begin
                    vector    = vec_cur & fill_mask;
                    head_next = '0;
                end
            end
            op_rd_wr: begin
                // old vector goes out, new bit opens the next one
                vector      = vec_cur & fill_mask;
                vec_next[0] = clean_bit.data;
                head_next   = head_t'(1);
            end
            default: begin
                head_next = head_cur;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        vec_cur <= vec_next;
        if (rst) begin
            head_cur <= '0;
        end else begin
            head_cur <= head_next;
        end
    end

endmodule : rng_bit_collector

// File: rng_debias.sv
`timescale 1ns/1ps

module rng_debias (
    input  logic              clk,
    input  logic              rst,
    input  rng_pkg::rng_bit_t checked_bit,
    output rng_pkg::rng_bit_t clean_bit
);

    import rng_pkg::*;

    vn_state_t state;
    vn_state_t state_next;
    logic      first_bit;
    rng_bit_t  clean_next;

    // von Neumann rule
    // 0,1 gives 0 and 1,0 gives 1, so the output is always the first bit
    always_comb begin
        state_next       = state;
        clean_next.valid = 1'b0;
        clean_next.data  = first_bit;
        if (checked_bit.valid) begin
            unique case (state)
                vn_wait_first: begin
                    state_next = vn_have_first;
                end
                vn_have_first: begin
                    state_next = vn_wait_first;
                    // equal pairs are discarded
                    clean_next.valid = checked_bit.data != first_bit;
                end
                default: begin
                    state_next = vn_wait_first;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (checked_bit.valid && state == vn_wait_first) begin
            first_bit <= checked_bit.data;
        end
        clean_bit.data <= clean_next.data;
        if (rst) begin
            state           <= vn_wait_first;
            clean_bit.valid <= 1'b0;
        end else begin
            state           <= state_next;
            clean_bit.valid <= clean_next.valid;
        end
    end

endmodule : rng_debias

// File: rng_health_monitor.sv
`timescale 1ns/1ps
`include "rng_settings.svh"

module rng_health_monitor (
    input  logic              clk,
    input  logic              rst,
    input  rng_pkg::rng_bit_t raw_bit,
    output rng_pkg::rng_bit_t checked_bit,
    output logic              alarm
);

    import rng_pkg::*;

    localparam int unsigned CNT_W = $clog2(`RCT_CUTOFF + 1);

    typedef logic [CNT_W-1:0] count_t;

    localparam count_t CUTOFF = count_t'(`RCT_CUTOFF);

    // zero means no bit seen since reset
    count_t   run_count;
    count_t   run_count_next;
    logic     last_bit;
    logic     alarm_next;
    rng_bit_t checked_next;

    always_comb begin
        run_count_next = run_count;
        if (raw_bit.valid) begin
            if (run_count != '0 && raw_bit.data == last_bit) begin
                // saturate so a long stuck run cannot wrap
                if (run_count != CUTOFF) begin
                    run_count_next = run_count + 1'b1;
                end
            end else begin
                run_count_next = count_t'(1);
            end
        end
    end

    // alarm is sticky until reset
    always_comb begin
        alarm_next = alarm;
        if (raw_bit.valid && run_count_next == CUTOFF) begin
            alarm_next = 1'b1;
        end
    end

    // tripping bit and everything after it are blocked
    always_comb begin
        checked_next.data  = raw_bit.data;
        checked_next.valid = raw_bit.valid & ~alarm_next;
    end

    always_ff @(posedge clk) begin
        checked_bit.data <= checked_next.data;
        if (raw_bit.valid) begin
            last_bit <= raw_bit.data;
        end
        if (rst) begin
            run_count         <= '0;
            alarm             <= 1'b0;
            checked_bit.valid <= 1'b0;
        end else begin
            run_count         <= run_count_next;
            alarm             <= alarm_next;
            checked_bit.valid <= checked_next.valid;
        end
    end

endmodule : rng_health_monitor

// File: rng_bit_extract.sv
`timescale 1ns/1ps

module rng_bit_extract (
    input  logic                clk,
    input  logic                rst,
    input  rng_pkg::adc_sample_t sample,
    input  logic                sample_valid,
    output rng_pkg::rng_bit_t   raw_bit
);

    import rng_pkg::*;

    rng_bit_t raw_bit_next;

    // the lsb carries most of the thermal noise
    always_comb begin
        raw_bit_next.valid = sample_valid;
        if (sample_valid) begin
            raw_bit_next.data = sample[0];
        end else begin
            raw_bit_next.data = raw_bit.data;
        end
    end

    // one register stage, strobe and bit move together
    always_ff @(posedge clk) begin
        raw_bit.data <= raw_bit_next.data;
        if (rst) begin
            raw_bit.valid <= 1'b0;
        end else begin
            raw_bit.valid <= raw_bit_next.valid;
        end
    end

endmodule : rng_bit_extract

// File: rng_pkg.sv
`include "rng_settings.svh"

package rng_pkg;

    // one raw sample from the converter
    typedef logic [`ADC_WIDTH-1:0] adc_sample_t;

    // one noise bit with its strobe, passed between pipeline stages
    typedef struct packed {
        logic data;
        logic valid;
    } rng_bit_t;

    // collected output bits, bit 0 is the oldest
    typedef logic [`RNG_VECTOR_DEPTH-1:0] rng_vector_t;

    // von Neumann pairing state
    typedef enum logic {
        vn_wait_first = 1'b0,
        vn_have_first = 1'b1
    } vn_state_t;

    // collector operation, encoded as {write, read}
    typedef enum logic [1:0] {
        op_idle  = 2'b00,
        op_rd    = 2'b01,
        op_wr    = 2'b10,
        op_rd_wr = 2'b11
    } collector_op_t;

endpackage : rng_pkg

// File: rng_settings.svh
`ifndef RNG_SETTINGS_SVH
`define RNG_SETTINGS_SVH

// width of one raw ADC sample
`define ADC_WIDTH 12

// number of debiased bits handed out per read
`define RNG_VECTOR_DEPTH 10

// repetition-count health test
// equal consecutive raw bits that count as a stuck source
`define RCT_CUTOFF 16

// collector fill counter
// must hold the value RNG_VECTOR_DEPTH
`define RNG_HEAD_WIDTH 4

`endif
